// File: flist.f
logic/laser_link_pkg.sv
logic/marker_detector.sv
logic/link_controller.sv
logic/frame_writer.sv
logic/laser_link_top.sv
dv/laser_link_tb.sv

// File: Makefile
SIM = obj_dir/laser_link_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module laser_link_tb -Mdir obj_dir -o laser_link_sim

run: compile
	./$(SIM) | tee sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/laser_link_tb.sv
`timescale 1ns/1ps

module laser_link_tb;

    localparam int PAYLOAD_LEN    = 16;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int WAIT_LIMIT     = 2 * TIMEOUT_CYCLES + 64;
    localparam int NUM_TESTS      = 6;
    // worst case length of one test in clock cycles
    localparam int TEST_CYCLES    = 8 * WAIT_LIMIT;
    localparam int RUN_NS         = NUM_TESTS * TEST_CYCLES * 4 + 1000;

    // progress sources for the wait task
    localparam int SRC_TX    = 0;
    localparam int SRC_OUT   = 1;
    localparam int SRC_PULSE = 2;
    localparam int SRC_DONE  = 3;

    typedef logic [7:0] byte_q_t[$];
    typedef logic [8:0] out_q_t[$];

    logic                       clock;
    logic                       reset;
    logic                       rx_valid;
    laser_link_pkg::link_byte_t rx_data;
    logic                       tx_valid;
    logic                       tx_ready;
    laser_link_pkg::link_byte_t tx_data;
    logic                       host_in_valid;
    logic                       host_in_ready;
    laser_link_pkg::host_byte_t host_in;
    logic                       host_out_valid;
    logic                       host_out_ready;
    laser_link_pkg::host_byte_t host_out;
    logic                       frame_error;

    logic [31:0] rng;
    string       test_name;
    byte_q_t     act_tx_q;
    byte_q_t     host_q;
    out_q_t      exp_out_q;
    int          out_count;
    int          error_pulses;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_passed;
    logic        feeding;

    laser_link_top #(
        .PAYLOAD_LEN    (PAYLOAD_LEN),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_laser_link_top (
        .clock          (clock),
        .reset          (reset),
        .rx_valid       (rx_valid),
        .rx_data        (rx_data),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .tx_data        (tx_data),
        .host_in_valid  (host_in_valid),
        .host_in_ready  (host_in_ready),
        .host_in        (host_in),
        .host_out_valid (host_out_valid),
        .host_out_ready (host_out_ready),
        .host_out       (host_out),
        .frame_error    (frame_error)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic laser_link_pkg::marker_t marker_of(input laser_link_pkg::marker_kind_t kind);
        laser_link_pkg::marker_t word;
        case (kind)
            laser_link_pkg::KIND_DATA: word = laser_link_pkg::DATA_MARKER;
            laser_link_pkg::KIND_STOP: word = laser_link_pkg::STOP_MARKER;
            default:                   word = laser_link_pkg::START_MARKER;
        endcase
        return word;
    endfunction

    // expected host_out words {data, last}: marker header, then payload
    function automatic out_q_t frame_reference(input laser_link_pkg::marker_kind_t kind,
                                               input byte_q_t payload);
        out_q_t                  frame;
        laser_link_pkg::marker_t word;
        int                      i;
        word  = marker_of(kind);
        frame = {};
        for (i = 0; i < 4; i++) begin
            frame.push_back({word[31-8*i -: 8], 1'b0});
        end
        for (i = 0; i < payload.size(); i++) begin
            frame.push_back({payload[i], i == PAYLOAD_LEN - 1});
        end
        return frame;
    endfunction

    function automatic int progress(input int source);
        int value;
        case (source)
            SRC_TX:    value = act_tx_q.size();
            SRC_OUT:   value = out_count;
            SRC_PULSE: value = error_pulses;
            default:   value = (exp_out_q.size() == 0) ? 1 : 0;
        endcase
        return value;
    endfunction

    // transfers sampled mid cycle, away from the driving edge
    always @(negedge clock) begin : monitor
        logic [8:0] got;
        logic [8:0] want;
        if (!reset) begin
            if (tx_valid && tx_ready) begin
                act_tx_q.push_back(tx_data);
            end
            if (host_out_valid && host_out_ready) begin
                got = host_out;
                out_count++;
                assert (exp_out_q.size() != 0) else begin
                    $display("test %s: host_out byte %h arrived with no frame expected",
                             test_name, got[8:1]);
                    errors++;
                end
                if (exp_out_q.size() != 0) begin
                    want = exp_out_q.pop_front();
                    assert (got == want) else begin
                        $display("mismatch %s host_out expected %h/%b actual %h/%b",
                                 test_name, want[8:1], want[0], got[8:1], got[0]);
                        errors++;
                    end
                end
            end
            if (frame_error) begin
                error_pulses++;
            end
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic send_rx(input laser_link_pkg::link_byte_t value);
        rx_valid = 1'b1;
        rx_data  = value;
        @(posedge clock);
        #1;
        rx_valid = 1'b0;
    endtask

    task automatic wait_progress(input int source, input int target, input string what);
        int cycles;
        cycles = 0;
        while (progress(source) < target && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        assert (progress(source) >= target) else begin
            $display("test %s: timed out waiting for %s", test_name, what);
            errors++;
        end
    endtask

    task automatic feed_host();
        int   i;
        logic fired;
        for (i = 0; i < host_q.size(); i++) begin
            host_in_valid = 1'b1;
            host_in.data  = host_q[i];
            host_in.last  = (i == host_q.size() - 1);
            fired = 1'b0;
            while (!fired) begin
                @(negedge clock);
                fired = host_in_ready;
                @(posedge clock);
                #1;
            end
        end
        host_in_valid = 1'b0;
        feeding       = 1'b0;
    endtask

    task automatic stall_tx();
        while (feeding) begin
            rng      = xorshift(rng);
            tx_ready = rng[0];
            @(posedge clock);
            #1;
        end
    endtask

    task automatic run_transmit(input int n_bytes, input logic stall);
        int i;
        int sent;
        int n_req;
        host_q = {};
        for (i = 0; i < n_bytes; i++) begin
            rng = xorshift(rng);
            host_q.push_back(rng[23:16]);
        end
        tx_ready = 1'b1;
        feeding  = 1'b1;
        fork
            feed_host();
            if (stall) stall_tx();
            begin
                wait_progress(SRC_TX, 1, "a handshake request on tx");
                send_rx(laser_link_pkg::HS_ACCEPT);
            end
        join
        tx_ready = 1'b1;
        sent = act_tx_q.size();
        idle_cycles(20);
        assert (act_tx_q.size() == sent) else begin
            $display("test %s: tx kept sending after the last host byte", test_name);
            errors++;
        end
        n_req = sent - n_bytes;
        assert (n_req >= 1) else begin
            $display("test %s: no handshake request came before the host bytes", test_name);
            errors++;
        end
        for (i = 0; i < n_req; i++) begin
            assert (act_tx_q[i] == laser_link_pkg::HS_REQUEST) else begin
                $display("mismatch %s tx request expected %h actual %h",
                         test_name, laser_link_pkg::HS_REQUEST, act_tx_q[i]);
                errors++;
            end
        end
        for (i = 0; i < n_bytes && n_req >= 0; i++) begin
            assert (act_tx_q[n_req+i] == host_q[i]) else begin
                $display("mismatch %s tx byte %0d expected %h actual %h",
                         test_name, i, host_q[i], act_tx_q[n_req+i]);
                errors++;
            end
        end
    endtask

    // frames shorter than PAYLOAD_LEN end through the payload timeout
    task automatic run_frame(input laser_link_pkg::marker_kind_t kind, input int n_payload);
        byte_q_t                 payload;
        laser_link_pkg::marker_t word;
        int                      i;
        int                      cycles;
        int                      pulses_before;
        int                      pulses_want;
        payload = {};
        for (i = 0; i < n_payload; i++) begin
            rng = xorshift(rng);
            payload.push_back(rng[15:8]);
        end
        exp_out_q     = frame_reference(kind, payload);
        out_count     = 0;
        pulses_before = error_pulses;
        pulses_want   = (n_payload >= PAYLOAD_LEN) ? pulses_before : pulses_before + 1;
        word = marker_of(kind);
        for (i = 0; i < 4; i++) begin
            send_rx(word[31-8*i -: 8]);
        end
        // header under random host back-pressure
        cycles = 0;
        while (out_count < 4 && cycles < WAIT_LIMIT) begin
            rng            = xorshift(rng);
            host_out_ready = rng[0];
            @(posedge clock);
            #1;
            cycles++;
        end
        host_out_ready = 1'b1;
        assert (out_count >= 4) else begin
            $display("test %s: the frame header never completed on host_out", test_name);
            errors++;
        end
        for (i = 0; i < n_payload; i++) begin
            send_rx(payload[i]);
        end
        if (n_payload >= PAYLOAD_LEN) begin
            wait_progress(SRC_DONE, 1, "the end of the frame");
        end else begin
            wait_progress(SRC_PULSE, pulses_want, "a frame_error pulse");
        end
        idle_cycles(8);
        assert (exp_out_q.size() == 0) else begin
            $display("test %s: host_out ended %0d bytes short", test_name, exp_out_q.size());
            errors++;
        end
        assert (error_pulses == pulses_want) else begin
            $display("mismatch %s frame_error pulses expected %0d actual %0d",
                     test_name, pulses_want - pulses_before, error_pulses - pulses_before);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        act_tx_q        = {};
        out_count       = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        reset          = 1'b1;
        rx_valid       = 1'b0;
        rx_data        = '0;
        tx_ready       = 1'b0;
        host_in_valid  = 1'b0;
        host_in        = '0;
        host_out_ready = 1'b0;
        rng            = 32'h6d37_2c20;
        test_name      = "reset";
        exp_out_q      = {};
        out_count      = 0;
        error_pulses   = 0;
        errors         = 0;
        tests_run      = 0;
        tests_passed   = 0;
        feeding        = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        idle_cycles(4);

        start_test("transmit");
        run_transmit(5, 1'b0);
        end_test();

        start_test("transmit_backpressure");
        run_transmit(8, 1'b1);
        end_test();

        start_test("receive_handshake");
        send_rx(laser_link_pkg::HS_REQUEST);
        wait_progress(SRC_TX, 1, "the accept byte on tx");
        idle_cycles(4);
        assert (act_tx_q.size() == 1) else begin
            $display("mismatch %s tx byte count expected 1 actual %0d",
                     test_name, act_tx_q.size());
            errors++;
        end
        if (act_tx_q.size() != 0) begin
            assert (act_tx_q[0] == laser_link_pkg::HS_ACCEPT) else begin
                $display("mismatch %s tx accept expected %h actual %h",
                         test_name, laser_link_pkg::HS_ACCEPT, act_tx_q[0]);
                errors++;
            end
        end
        run_frame(laser_link_pkg::KIND_START, PAYLOAD_LEN);
        assert (act_tx_q.size() == 1) else begin
            $display("test %s: tx sent bytes during the received frame", test_name);
            errors++;
        end
        end_test();

        start_test("marker_kinds");
        run_frame(laser_link_pkg::KIND_DATA, PAYLOAD_LEN);
        idle_cycles(4);
        run_frame(laser_link_pkg::KIND_STOP, PAYLOAD_LEN);
        end_test();

        start_test("broken_markers");
        send_rx(laser_link_pkg::START_MARKER[31:24]);
        send_rx(8'h00);
        send_rx(laser_link_pkg::DATA_MARKER[31:24]);
        send_rx(laser_link_pkg::DATA_MARKER[23:16]);
        send_rx(8'h00);
        send_rx(laser_link_pkg::STOP_MARKER[31:24]);
        send_rx(laser_link_pkg::STOP_MARKER[23:16]);
        send_rx(laser_link_pkg::STOP_MARKER[15:8]);
        send_rx(8'h00);
        idle_cycles(8);
        assert (out_count == 0) else begin
            $display("test %s: a partial marker produced host_out bytes", test_name);
            errors++;
        end
        run_frame(laser_link_pkg::KIND_START, PAYLOAD_LEN);
        end_test();

        start_test("timeout");
        run_frame(laser_link_pkg::KIND_START, 6);
        idle_cycles(4);
        run_frame(laser_link_pkg::KIND_START, PAYLOAD_LEN);
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog sized from the test lengths at 4 ns per cycle
    initial begin
        #(RUN_NS);
        $display("watchdog expired in test %s, the run did not finish", test_name);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: logic/laser_link_top.sv
`timescale 1ns/1ps

module laser_link_top #(
    parameter int PAYLOAD_LEN    = 1024,
    parameter int TIMEOUT_CYCLES = 1024
) (
    input  logic                       clock,
    input  logic                       reset,
    // laser receiver, cannot be stalled
    input  logic                       rx_valid,
    input  laser_link_pkg::link_byte_t rx_data,
    // laser transmitter
    output logic                       tx_valid,
    input  logic                       tx_ready,
    output laser_link_pkg::link_byte_t tx_data,
    // host to link
    input  logic                       host_in_valid,
    output logic                       host_in_ready,
    input  laser_link_pkg::host_byte_t host_in,
    // link to host
    output logic                       host_out_valid,
    input  logic                       host_out_ready,
    output laser_link_pkg::host_byte_t host_out,
    output logic                       frame_error
);

    laser_link_pkg::rx_event_t    rx_event;
    laser_link_pkg::marker_kind_t frame_kind;
    logic                         frame_start;
    logic                         frame_busy;

    marker_detector u_marker_detector (
        .clock    (clock),
        .reset    (reset),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .rx_event (rx_event)
    );

    link_controller #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_link_controller (
        .clock         (clock),
        .reset         (reset),
        .rx_event      (rx_event),
        .host_in_valid (host_in_valid),
        .host_in       (host_in),
        .host_in_ready (host_in_ready),
        .tx_valid      (tx_valid),
        .tx_ready      (tx_ready),
        .tx_data       (tx_data),
        .frame_busy    (frame_busy),
        .frame_start   (frame_start),
        .frame_kind    (frame_kind)
    );

    frame_writer #(
        .PAYLOAD_LEN    (PAYLOAD_LEN),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_frame_writer (
        .clock          (clock),
        .reset          (reset),
        .frame_start    (frame_start),
        .frame_kind     (frame_kind),
        .rx_event       (rx_event),
        .frame_busy     (frame_busy),
        .host_out_valid (host_out_valid),
        .host_out_ready (host_out_ready),
        .host_out       (host_out),
        .frame_error    (frame_error)
    );

endmodule

// File: logic/frame_writer.sv
`timescale 1ns/1ps

module frame_writer #(
    parameter int PAYLOAD_LEN    = 1024,
    parameter int TIMEOUT_CYCLES = 1024
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         frame_start,
    input  laser_link_pkg::marker_kind_t frame_kind,
    input  laser_link_pkg::rx_event_t    rx_event,
    output logic                         frame_busy,
    output logic                         host_out_valid,
    input  logic                         host_out_ready,
    output laser_link_pkg::host_byte_t   host_out,
    output logic                         frame_error
);

    localparam int COUNT_W = $clog2(PAYLOAD_LEN + 1);
    localparam int TIMER_W = $clog2(TIMEOUT_CYCLES + 1);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD
    } writer_state_t;

    writer_state_t           state;
    laser_link_pkg::marker_t start_word;
    laser_link_pkg::marker_t header_rest;
    logic [1:0]              header_left;
    logic [COUNT_W-1:0]      payload_count;
    logic [TIMER_W-1:0]      idle_count;
    logic                    out_fire;
    logic                    out_free;
    logic                    all_loaded;
    logic                    header_next;
    logic                    header_done;
    logic                    payload_take;
    logic                    last_sent;
    logic                    timed_out;

    assign start_word = laser_link_pkg::marker_word(frame_kind);
    assign frame_busy = state != IDLE;

    assign out_fire   = host_out_valid && host_out_ready;
    // output register can take a byte this cycle
    assign out_free   = !host_out_valid || host_out_ready;
    assign all_loaded = payload_count == COUNT_W'(PAYLOAD_LEN);

    assign header_next  = state == HEADER && out_fire && header_left != 2'd0;
    assign header_done  = state == HEADER && out_fire && header_left == 2'd0;
    assign payload_take = state == PAYLOAD && rx_event.valid && out_free && !all_loaded;
    assign last_sent    = state == PAYLOAD && out_fire && host_out.last;
    assign timed_out    = state == PAYLOAD && !all_loaded && !rx_event.valid
                          && idle_count == TIMER_W'(TIMEOUT_CYCLES - 1);

    // output byte and header shift register
    always_ff @(posedge clock) begin
        if (frame_start) begin
            host_out.data <= start_word[31:24];
            host_out.last <= 1'b0;
            header_rest   <= start_word << 8;
        end else if (header_next) begin
            host_out.data <= header_rest[31:24];
            host_out.last <= 1'b0;
            header_rest   <= header_rest << 8;
        end else if (payload_take) begin
            host_out.data <= rx_event.data;
            host_out.last <= payload_count == COUNT_W'(PAYLOAD_LEN - 1);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= IDLE;
            host_out_valid <= 1'b0;
            header_left    <= '0;
            payload_count  <= '0;
            idle_count     <= '0;
            frame_error    <= 1'b0;
        end else begin
            frame_error <= timed_out;
            case (state)
                IDLE: begin
                    if (frame_start) begin
                        state          <= HEADER;
                        host_out_valid <= 1'b1;
                        header_left    <= 2'd3;
                    end
                end
                HEADER: begin
                    if (header_next) begin
                        header_left <= header_left - 2'd1;
                    end else if (header_done) begin
                        state          <= PAYLOAD;
                        host_out_valid <= 1'b0;
                        payload_count  <= '0;
                        idle_count     <= '0;
                    end
                end
                PAYLOAD: begin
                    if (timed_out || last_sent) begin
                        // stalled frame drops whatever is still held
                        state          <= IDLE;
                        host_out_valid <= 1'b0;
                    end else if (payload_take) begin
                        host_out_valid <= 1'b1;
                        payload_count  <= payload_count + 1'b1;
                    end else if (out_fire) begin
                        host_out_valid <= 1'b0;
                    end
                    if (rx_event.valid) begin
                        idle_count <= '0;
                    end else begin
                        idle_count <= idle_count + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_start_when_free: assert property (@(posedge clock) disable iff (reset)
        frame_start |-> !frame_busy);

endmodule

// File: logic/link_controller.sv
`timescale 1ns/1ps

module link_controller #(
    parameter int TIMEOUT_CYCLES = 1024
) (
    input  logic                         clock,
    input  logic                         reset,
    input  laser_link_pkg::rx_event_t    rx_event,
    input  logic                         host_in_valid,
    input  laser_link_pkg::host_byte_t   host_in,
    output logic                         host_in_ready,
    output logic                         tx_valid,
    input  logic                         tx_ready,
    output laser_link_pkg::link_byte_t   tx_data,
    input  logic                         frame_busy,
    output logic                         frame_start,
    output laser_link_pkg::marker_kind_t frame_kind
);

    localparam int TIMER_W = $clog2(TIMEOUT_CYCLES + 1);

    typedef enum logic [2:0] {
        IDLE,
        TX_HANDSHAKE,
        TX_STREAM,
        RX_ACCEPT,
        RX_WAIT,
        RX_FRAME
    } link_state_t;

    link_state_t        state;
    link_state_t        state_next;
    logic               accepted;
    logic [TIMER_W-1:0] wait_count;
    logic               marker_event;
    logic               request_event;
    logic               accept_event;
    logic               wait_expired;

    assign marker_event  = rx_event.valid && rx_event.kind != laser_link_pkg::KIND_NONE;
    assign request_event = rx_event.valid && rx_event.hs_request;
    assign accept_event  = rx_event.valid && rx_event.hs_accept;
    assign wait_expired  = !rx_event.valid && wait_count == TIMER_W'(TIMEOUT_CYCLES - 1);

    // frame writer only looks at the kind while frame_start is high
    assign frame_kind = rx_event.kind;

    always_comb begin
        state_next    = state;
        tx_valid      = 1'b0;
        tx_data       = '0;
        host_in_ready = 1'b0;
        frame_start   = 1'b0;
        case (state)
            IDLE: begin
                if (host_in_valid) begin
                    state_next = TX_HANDSHAKE;
                end else if (marker_event) begin
                    frame_start = 1'b1;
                    state_next  = RX_FRAME;
                end else if (request_event) begin
                    state_next = RX_ACCEPT;
                end
            end
            TX_HANDSHAKE: begin
                // keep requesting, leave only once a request byte has gone out
                tx_valid = 1'b1;
                tx_data  = laser_link_pkg::HS_REQUEST;
                if (tx_ready && (accepted || accept_event)) begin
                    state_next = TX_STREAM;
                end
            end
            TX_STREAM: begin
                tx_valid      = host_in_valid;
                tx_data       = host_in.data;
                host_in_ready = tx_ready;
                if (host_in_valid && tx_ready && host_in.last) begin
                    state_next = IDLE;
                end
            end
            RX_ACCEPT: begin
                tx_valid = 1'b1;
                tx_data  = laser_link_pkg::HS_ACCEPT;
                if (tx_ready) begin
                    state_next = RX_WAIT;
                end
            end
            RX_WAIT: begin
                if (marker_event) begin
                    frame_start = 1'b1;
                    state_next  = RX_FRAME;
                end else if (request_event) begin
                    // far end missed our accept
                    state_next = RX_ACCEPT;
                end else if (wait_expired) begin
                    state_next = IDLE;
                end
            end
            RX_FRAME: begin
                if (!frame_busy) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            accepted   <= 1'b0;
            wait_count <= '0;
        end else begin
            state <= state_next;
            // accept seen while a request byte is still pending
            if (state != TX_HANDSHAKE) begin
                accepted <= 1'b0;
            end else if (accept_event) begin
                accepted <= 1'b1;
            end
            if (state != RX_WAIT || rx_event.valid) begin
                wait_count <= '0;
            end else begin
                wait_count <= wait_count + 1'b1;
            end
        end
    end

    a_tx_hold: assert property (@(posedge clock) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

// File: logic/marker_detector.sv
`timescale 1ns/1ps

module marker_detector (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       rx_valid,
    input  laser_link_pkg::link_byte_t rx_data,
    output laser_link_pkg::rx_event_t  rx_event
);

    // number of marker bytes matched so far
    typedef enum logic [1:0] {
        SEARCH,
        MATCH_1,
        MATCH_2,
        MATCH_3
    } match_state_t;

    match_state_t                 state;
    match_state_t                 state_next;
    laser_link_pkg::marker_kind_t tracked;
    laser_link_pkg::marker_kind_t tracked_next;
    laser_link_pkg::marker_kind_t first_kind;
    laser_link_pkg::marker_kind_t found_kind;
    laser_link_pkg::marker_t      tracked_word;
    laser_link_pkg::link_byte_t   expected;
    logic                         hs_request;
    logic                         hs_accept;

    // marker whose first byte equals the incoming byte
    always_comb begin
        if (rx_data == laser_link_pkg::START_MARKER[31:24]) begin
            first_kind = laser_link_pkg::KIND_START;
        end else if (rx_data == laser_link_pkg::DATA_MARKER[31:24]) begin
            first_kind = laser_link_pkg::KIND_DATA;
        end else if (rx_data == laser_link_pkg::STOP_MARKER[31:24]) begin
            first_kind = laser_link_pkg::KIND_STOP;
        end else begin
            first_kind = laser_link_pkg::KIND_NONE;
        end
    end

    // next byte expected of the tracked marker
    assign tracked_word = laser_link_pkg::marker_word(tracked);

    always_comb begin
        case (state)
            MATCH_1: expected = tracked_word[23:16];
            MATCH_2: expected = tracked_word[15:8];
            default: expected = tracked_word[7:0];
        endcase
    end

    always_comb begin
        state_next   = state;
        tracked_next = tracked;
        found_kind   = laser_link_pkg::KIND_NONE;
        if (rx_valid) begin
            if (state != SEARCH && rx_data == expected) begin
                if (state == MATCH_3) begin
                    found_kind = tracked;
                    state_next = SEARCH;
                end else begin
                    state_next = match_state_t'(state + 2'd1);
                end
            end else if (first_kind != laser_link_pkg::KIND_NONE) begin
                // mismatch byte may itself open a new marker
                state_next   = MATCH_1;
                tracked_next = first_kind;
            end else begin
                state_next = SEARCH;
            end
        end
    end

    // handshake bytes only count outside a partial marker
    assign hs_request = rx_valid && state == SEARCH && rx_data == laser_link_pkg::HS_REQUEST;
    assign hs_accept  = rx_valid && state == SEARCH && rx_data == laser_link_pkg::HS_ACCEPT;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= SEARCH;
            tracked  <= laser_link_pkg::KIND_NONE;
            rx_event <= '0;
        end else begin
            state               <= state_next;
            tracked             <= tracked_next;
            rx_event.valid      <= rx_valid;
            rx_event.hs_request <= hs_request;
            rx_event.hs_accept  <= hs_accept;
            rx_event.kind       <= found_kind;
            rx_event.data       <= rx_data;
        end
    end

    a_single_event_kind: assert property (@(posedge clock) disable iff (reset)
        $onehot0({rx_event.hs_request, rx_event.hs_accept,
                  rx_event.kind != laser_link_pkg::KIND_NONE}));

endmodule

// File: logic/laser_link_pkg.sv
package laser_link_pkg;

    // one byte on the laser or host side
    typedef logic [7:0] link_byte_t;

    // marker word, first byte on the wire sits in [31:24]
    typedef logic [31:0] marker_t;

    localparam marker_t START_MARKER = 32'hc1c2_c3c4;
    localparam marker_t DATA_MARKER  = 32'hd1d2_d3d4;
    localparam marker_t STOP_MARKER  = 32'h5152_5354;

    // handshake bytes
    localparam link_byte_t HS_REQUEST = 8'haa;
    localparam link_byte_t HS_ACCEPT  = 8'h10;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_START,
        KIND_DATA,
        KIND_STOP
    } marker_kind_t;

    // one decoded rx byte
    // kind other than KIND_NONE marks a completed marker
    typedef struct packed {
        logic         valid;
        logic         hs_request;
        logic         hs_accept;
        marker_kind_t kind;
        link_byte_t   data;
    } rx_event_t;

    // host side byte with end of frame flag
    typedef struct packed {
        link_byte_t data;
        logic       last;
    } host_byte_t;

    // marker word for a marker kind
    function automatic marker_t marker_word(input marker_kind_t kind);
        marker_t word;
        case (kind)
            KIND_START: word = START_MARKER;
            KIND_DATA:  word = DATA_MARKER;
            KIND_STOP:  word = STOP_MARKER;
            default:    word = '0;
        endcase
        return word;
    endfunction

endpackage
